//--- src.f
+incdir+include
logic/fir_types_pkg.sv
logic/fir_coef_pkg.sv
logic/shift_reg.sv
logic/fir_filter.sv
logic/fir_output_scaler.sv
logic/fir_top.sv
verif/tb_fir_top.sv

//--- Bender.yml
package:
  name: fir_lowpass

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/fir_types_pkg.sv
      - logic/fir_coef_pkg.sv
      - logic/shift_reg.sv
      - logic/fir_filter.sv
      - logic/fir_output_scaler.sv
      - logic/fir_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_fir_top.sv

//--- verif/tb_fir_top.sv
// Testbench for the FIR low-pass stage.
// Table-driven stimulus through fir_top with a reference convolution
// model. A monitor checks every output against the model, including
// its latency in enabled edges.

`timescale 1ns/1ps
`default_nettype none

`include "fir_macros.svh"

module tb_fir_top
    import fir_types_pkg::*, fir_coef_pkg::*;
();

    localparam int MAX_TESTS   = 8;
    localparam int PAT_IMPULSE = 0;
    localparam int PAT_STEP    = 1;
    localparam int PAT_FULL    = 2;
    localparam int PAT_RANDOM  = 3;

    logic    clk;
    logic    rstn;
    logic    en;
    logic    tvalid_in;
    sample_t tdata_in;
    logic    tlast_in;
    logic    tvalid_out;
    sample_t tdata_out;
    logic    tlast_out;
    logic    sat_out;

    // test table with one entry per row.
    string   row_name [MAX_TESTS];
    int      row_pattern [MAX_TESTS];
    int      row_samples [MAX_TESTS];
    int      row_gap [MAX_TESTS];
    int      row_stall_every [MAX_TESTS];
    int      row_stall_len [MAX_TESTS];
    int      row_last_idx [MAX_TESTS];
    bit      row_need_sat [MAX_TESTS];
    int      num_tests;

    longint  hist [`FIR_TAP_NUM];  // model history with the newest first.
    int      exp_data_q [$];
    bit      exp_last_q [$];
    bit      exp_sat_q [$];
    int      exp_edge_q [$];

    integer  seed;
    string   cur_name;
    int      en_edges;
    int      cycle_count;
    int      cycle_limit;
    int      out_count;
    int      sat_count;
    int      mismatch_count;
    int      other_count;

    fir_top UUT (
        .clk_i   (clk),
        .rstn_i  (rstn),
        .en_i    (en),
        .tvalid_i(tvalid_in),
        .tdata_i (tdata_in),
        .tlast_i (tlast_in),
        .tvalid_o(tvalid_out),
        .tdata_o (tdata_out),
        .tlast_o (tlast_out),
        .sat_o   (sat_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (en === 1'b1) begin
            en_edges++;  // pipeline only moves on these.
        end
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not complete", cycle_count);
            $display("Errors: %0d mismatches, %0d other failures", mismatch_count,
                     other_count + 1);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_value(input string what, input longint expected, input longint actual);
        if (expected != actual) begin
            $display("Mismatch %s %s: expected %0d, actual %0d", cur_name, what, expected, actual);
            mismatch_count++;
        end
    endtask

    // outputs are taken while en_i is high before an enabled edge.
    always @(negedge clk) begin
        if (rstn === 1'b1) begin
            if (tvalid_out !== 1'b1 && (tlast_out !== 1'b0 || sat_out !== 1'b0)) begin
                $display("%s: tlast_o or sat_o is set without tvalid_o", cur_name);
                other_count++;
            end
            if (en !== 1'b1 && tvalid_out !== 1'b0) begin
                $display("%s: tvalid_o is not low while en_i is low", cur_name);
                other_count++;
            end else if (tvalid_out === 1'b1) begin
                out_count++;
                if (sat_out === 1'b1) begin
                    sat_count++;
                end
                if (exp_data_q.size() == 0) begin
                    $display("%s: an output arrived with no accepted sample to match it",
                             cur_name);
                    other_count++;
                end else begin
                    check_value("data", exp_data_q.pop_front(), tdata_out);
                    check_value("last", exp_last_q.pop_front(), tlast_out);
                    check_value("sat", exp_sat_q.pop_front(), sat_out);
                    check_value("latency", `FIR_TOP_LATENCY,
                                en_edges - exp_edge_q.pop_front() + 1);
                end
            end else if (tvalid_out !== 1'b0) begin
                $display("%s: tvalid_o is unknown after reset", cur_name);
                other_count++;
            end
        end
    end

    task automatic add_row(input string name, input int pattern, input int samples,
                           input int gap, input int stall_every, input int stall_len,
                           input int last_idx, input bit need_sat);
        row_name[num_tests]        = name;
        row_pattern[num_tests]     = pattern;
        row_samples[num_tests]     = samples;
        row_gap[num_tests]         = gap;
        row_stall_every[num_tests] = stall_every;
        row_stall_len[num_tests]   = stall_len;
        row_last_idx[num_tests]    = last_idx;
        row_need_sat[num_tests]    = need_sat;
        num_tests++;
    endtask

    // mid-stream stalls plus one while the tail drains.
    function automatic int stall_cycles(input int t);
        if (row_stall_every[t] == 0) begin
            return 0;
        end
        return ((row_samples[t] - 1) / row_stall_every[t] + 1) * row_stall_len[t];
    endfunction

    function automatic int next_sample(input int pattern, input int i);
        int x;
        case (pattern)
            PAT_IMPULSE: x = (i == 0) ? 16384 : 0;
            PAT_STEP:    x = 20000;
            PAT_FULL:    x = (FIR_COEFS[i % `FIR_TAP_NUM] < 0) ? -32768 : 32767;
            default:     x = int'(sample_t'($random(seed)));
        endcase
        return x;
    endfunction

    // convolve and round half up, then drop the fraction bits and clamp.
    task automatic model_accept(input int x, input bit last, input int edge_n);
        longint acc;
        longint scaled;
        longint max_val;
        longint min_val;
        bit     clipped;
        max_val = (longint'(1) <<< (`FIR_DATA_WIDTH - 1)) - 1;
        min_val = -(longint'(1) <<< (`FIR_DATA_WIDTH - 1));
        for (int i = `FIR_TAP_NUM - 1; i > 0; i--) begin
            hist[i] = hist[i-1];
        end
        hist[0] = x;
        acc = 0;
        for (int i = 0; i < `FIR_TAP_NUM; i++) begin
            acc += hist[i] * longint'(FIR_COEFS[i]);
        end
        scaled  = (acc + (longint'(1) <<< (`FIR_COEF_FRAC - 1))) >>> `FIR_COEF_FRAC;
        clipped = 1'b1;
        if (scaled > max_val) begin
            scaled = max_val;
        end else if (scaled < min_val) begin
            scaled = min_val;
        end else begin
            clipped = 1'b0;
        end
        exp_data_q.push_back(int'(scaled));
        exp_last_q.push_back(last);
        exp_sat_q.push_back(clipped);
        exp_edge_q.push_back(edge_n);
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic run_test(input int t);
        int x;
        int gap_n;
        int drain;
        cur_name  = row_name[t];
        out_count = 0;
        sat_count = 0;
        rstn      = 1'b0;
        en        = 1'b1;
        tvalid_in = 1'b0;
        tlast_in  = 1'b0;
        tdata_in  = '0;
        for (int i = 0; i < `FIR_TAP_NUM; i++) begin
            hist[i] = 0;
        end
        repeat (4) step();
        rstn = 1'b1;
        step();  // idle cycle where nothing may come out.
        for (int i = 0; i < row_samples[t]; i++) begin
            x         = next_sample(row_pattern[t], i);
            tdata_in  = sample_t'(x);
            tvalid_in = 1'b1;
            tlast_in  = (i == row_last_idx[t]);
            if (row_stall_every[t] > 0 && i > 0 && i % row_stall_every[t] == 0) begin
                en = 1'b0;  // sample offered but must not be taken.
                repeat (row_stall_len[t]) step();
                en = 1'b1;
            end
            step();
            model_accept(x, tlast_in, en_edges);
            tvalid_in = 1'b0;
            tlast_in  = 1'b0;
            tdata_in  = sample_t'(~x);  // junk while idle.
            gap_n     = (row_gap[t] == 0) ? 0 : i % (row_gap[t] + 1);
            repeat (gap_n) step();
        end
        if (row_stall_every[t] > 0) begin
            repeat (2) step();
            en = 1'b0;  // results still in flight.
            repeat (row_stall_len[t]) step();
            en = 1'b1;
        end
        drain = 0;
        while (exp_data_q.size() > 0 && drain < `FIR_TOP_LATENCY + 8) begin
            step();
            drain++;
        end
        if (exp_data_q.size() > 0) begin
            $display("%s: %0d expected outputs never arrived", cur_name, exp_data_q.size());
            other_count++;
            exp_data_q.delete();
            exp_last_q.delete();
            exp_sat_q.delete();
            exp_edge_q.delete();
        end
        repeat (2) step();
        check_value("output count", row_samples[t], out_count);
        if (row_need_sat[t]) begin
            check_value("clipped outputs seen", 1, sat_count > 0);
        end
    endtask

    initial begin
        seed           = 32'he2b;
        rstn           = 1'b0;
        en             = 1'b0;
        tvalid_in      = 1'b0;
        tdata_in       = '0;
        tlast_in       = 1'b0;
        en_edges       = 0;
        cycle_count    = 0;
        mismatch_count = 0;
        other_count    = 0;
        num_tests      = 0;
        cur_name       = "reset";

        //      name             pattern      n   gap every len last sat
        add_row("impulse",       PAT_IMPULSE, 24, 0,  0,    0,  23,  1'b0);
        add_row("step",          PAT_STEP,    24, 0,  0,    0,  23,  1'b0);
        add_row("full_scale",    PAT_FULL,    40, 0,  0,    0,  39,  1'b1);
        add_row("random_gaps",   PAT_RANDOM,  48, 3,  0,    0,  47,  1'b0);
        add_row("random_stalls", PAT_RANDOM,  48, 1,  10,   5,  30,  1'b0);
        add_row("frame_marker",  PAT_RANDOM,  20, 0,  6,    2,  9,   1'b0);

        cycle_limit = 0;
        for (int t = 0; t < num_tests; t++) begin
            cycle_limit += row_samples[t] * (1 + row_gap[t]) + stall_cycles(t)
                           + `FIR_TOP_LATENCY + 8;
        end

        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/fir_top.sv
// FIR low-pass stage top.
// Filter core followed by the round and saturate stage. Plain strobes
// with a global clock enable; there is no back-pressure.

`timescale 1ns/1ps
`default_nettype none

module fir_top
    import fir_types_pkg::*;
(
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    en_i,

    input  logic    tvalid_i,
    input  sample_t tdata_i,
    input  logic    tlast_i,

    output logic    tvalid_o,
    output sample_t tdata_o,
    output logic    tlast_o,
    output logic    sat_o
);

    logic acc_valid;
    logic acc_last;
    acc_t acc_data;

    fir_filter i_fir_filter (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .en_i       (en_i),
        .tvalid_i   (tvalid_i),
        .tlast_i    (tlast_i),
        .tdata_i    (tdata_i),
        .acc_valid_o(acc_valid),
        .acc_last_o (acc_last),
        .acc_data_o (acc_data)
    );

    fir_output_scaler i_fir_output_scaler (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .en_i       (en_i),
        .acc_valid_i(acc_valid),
        .acc_last_i (acc_last),
        .acc_data_i (acc_data),
        .tvalid_o   (tvalid_o),
        .tlast_o    (tlast_o),
        .sat_o      (sat_o),
        .tdata_o    (tdata_o)
    );

endmodule

`default_nettype wire

//--- logic/fir_output_scaler.sv
// FIR output scaler.
// Rounds the tree sum half up, drops the coefficient fraction bits and
// clamps to the sample range, flagging clipped outputs. One register
// stage, held while en_i is low.

`timescale 1ns/1ps
`default_nettype none

`include "fir_macros.svh"

module fir_output_scaler
    import fir_types_pkg::*;
(
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    en_i,

    input  logic    acc_valid_i,
    input  logic    acc_last_i,
    input  acc_t    acc_data_i,

    output logic    tvalid_o,
    output logic    tlast_o,
    output logic    sat_o,
    output sample_t tdata_o
);

    localparam acc_t ROUND_HALF = acc_t'(1) <<< (`FIR_COEF_FRAC - 1);
    localparam acc_t SAT_MAX    = acc_t'((2 ** (`FIR_DATA_WIDTH - 1)) - 1);
    localparam acc_t SAT_MIN    = acc_t'(-(2 ** (`FIR_DATA_WIDTH - 1)));

    acc_t    rounded;
    acc_t    shifted;
    sample_t sample_next;
    logic    clip;

    logic    valid_q;
    logic    last_q;
    logic    sat_q;
    sample_t data_q;

    assign rounded = acc_data_i + ROUND_HALF;
    assign shifted = rounded >>> `FIR_COEF_FRAC;

    always_comb begin
        clip        = 1'b1;
        sample_next = sample_t'(shifted);
        if (shifted > SAT_MAX) begin
            sample_next = sample_t'(SAT_MAX);
        end else if (shifted < SAT_MIN) begin
            sample_next = sample_t'(SAT_MIN);
        end else begin
            clip = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            sat_q   <= 1'b0;
        end else if (en_i) begin
            valid_q <= acc_valid_i;
            last_q  <= acc_valid_i & acc_last_i;
            sat_q   <= acc_valid_i & clip;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            data_q <= sample_next;
        end
    end

    // held outputs stay hidden until the consumer re-enables.
    assign tvalid_o = valid_q & en_i;
    assign tlast_o  = last_q & en_i;
    assign sat_o    = sat_q & en_i;
    assign tdata_o  = data_q;

    // a clipped output sits on one of the two rails.
    a_sat_on_rail: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        sat_o |-> (tdata_o == sample_t'(SAT_MAX) || tdata_o == sample_t'(SAT_MIN))
    ) else $error("fir_output_scaler: sat_o with an unclamped tdata_o");

endmodule

`default_nettype wire

//--- logic/fir_filter.sv
// FIR filter core.
// 16-tap delay line fed by accepted samples, one registered multiply
// per tap and a four-level registered adder tree. The valid and last
// flags ride a matching control pipeline so several samples can be in
// flight. Every register holds while en_i is low.

`timescale 1ns/1ps
`default_nettype none

`include "fir_macros.svh"

module fir_filter
    import fir_types_pkg::*, fir_coef_pkg::*;
(
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    en_i,

    input  logic    tvalid_i,
    input  logic    tlast_i,
    input  sample_t tdata_i,

    output logic    acc_valid_o,
    output logic    acc_last_o,
    output acc_t    acc_data_o
);

    localparam int TAPS   = `FIR_TAP_NUM;
    localparam int LEVELS = `FIR_TREE_LEVELS;

    sample_t   taps_q [TAPS];
    product_t  prod_q [TAPS];
    acc_t      tree_q [LEVELS][TAPS/2];

    fir_ctrl_t ctrl_in;
    fir_ctrl_t ctrl_out;

    logic      accept;

    assign accept = en_i & tvalid_i;

    // history only moves on accepted samples.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < TAPS; i++) begin
                taps_q[i] <= '0;
            end
        end else if (accept) begin
            taps_q[0] <= tdata_i;
            for (int i = 1; i < TAPS; i++) begin
                taps_q[i] <= taps_q[i-1];
            end
        end
    end

    for (genvar t = 0; t < TAPS; t++) begin : g_mult
        always_ff @(posedge clk_i) begin
            if (en_i) begin
                prod_q[t] <= taps_q[t] * FIR_COEFS[t];
            end
        end
    end

    // level l holds TAPS >> (l+1) partial sums.
    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        for (genvar n = 0; n < (TAPS >> (l + 1)); n++) begin : g_node
            if (l == 0) begin : g_leaf
                always_ff @(posedge clk_i) begin
                    if (en_i) begin
                        tree_q[l][n] <= acc_t'(prod_q[2*n]) + acc_t'(prod_q[2*n+1]);
                    end
                end
            end else begin : g_inner
                always_ff @(posedge clk_i) begin
                    if (en_i) begin
                        tree_q[l][n] <= tree_q[l-1][2*n] + tree_q[l-1][2*n+1];
                    end
                end
            end
        end
    end

    assign ctrl_in.valid = tvalid_i;
    assign ctrl_in.last  = tlast_i;

    shift_reg #(
        .T       (fir_ctrl_t),
        .DELAY   (`FIR_FILTER_LATENCY),
        .RESET_EN(1'b1)
    ) i_ctrl_pipe (
        .clk_i (clk_i),
        .rstn_i(rstn_i),
        .en_i  (en_i),
        .data_i(ctrl_in),
        .data_o(ctrl_out)
    );

    // a result held over a stall is shown on the next enabled cycle.
    assign acc_valid_o = ctrl_out.valid & en_i;
    assign acc_last_o  = ctrl_out.last;
    assign acc_data_o  = tree_q[LEVELS-1][0];

    // a result due during a stall must still be waiting when en_i returns.
    a_hold_in_stall: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !en_i |=> $stable(acc_data_o) && $stable(ctrl_out)
    ) else $error("fir_filter: pipeline output moved while en_i is low");

    // balanced tree needs exactly 2**LEVELS leaves.
    if ((1 << LEVELS) != TAPS) begin : g_tree_check
        $error("fir_filter: %0d taps do not fit a %0d-level tree", TAPS, LEVELS);
    end

endmodule

`default_nettype wire

//--- logic/shift_reg.sv
// Generic delay line.
// DELAY registers of any type, advancing only while enabled. The chain
// can optionally be cleared by reset.

`timescale 1ns/1ps
`default_nettype none

module shift_reg #(
    parameter type T        = logic,
    parameter int  DELAY    = 1,
    parameter bit  RESET_EN = 1'b0
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic en_i,

    input  T     data_i,
    output T     data_o
);

    T stage_q [DELAY];

    always_ff @(posedge clk_i) begin
        if (RESET_EN && !rstn_i) begin
            for (int i = 0; i < DELAY; i++) begin
                stage_q[i] <= '0;
            end
        end else if (en_i) begin
            stage_q[0] <= data_i;
            for (int i = 1; i < DELAY; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign data_o = stage_q[DELAY-1];

    // a zero-length line has no register to hold the data.
    if (DELAY < 1) begin : g_delay_check
        $error("shift_reg: DELAY must be at least 1, got %0d", DELAY);
    end

endmodule

`default_nettype wire

//--- logic/fir_coef_pkg.sv
// FIR coefficient table.
// Fixed symmetric low-pass response, 16 taps in Q2.15. The taps sum to
// unity gain; the negative side lobes let a sign-matched full-scale
// input exceed the output range.

`default_nettype none

`include "fir_macros.svh"

package fir_coef_pkg;

    typedef logic signed [`FIR_COEF_WIDTH-1:0] coef_t;

    // index 0 multiplies the newest sample.
    localparam coef_t FIR_COEFS [0:`FIR_TAP_NUM-1] = '{
        -18'sd300,
        -18'sd650,
        -18'sd900,
        -18'sd608,
        18'sd1800,
        18'sd4000,
        18'sd6042,
        18'sd7000,
        18'sd7000,   // centre pair.
        18'sd6042,
        18'sd4000,
        18'sd1800,
        -18'sd608,
        -18'sd900,
        -18'sd650,
        -18'sd300
    };

endpackage

`default_nettype wire

//--- logic/fir_types_pkg.sv
// FIR datapath types.
// Sample, product and accumulator words plus the control word that
// travels beside the data pipeline.

`default_nettype none

`include "fir_macros.svh"

package fir_types_pkg;

    // input and output samples.
    typedef logic signed [`FIR_DATA_WIDTH-1:0] sample_t;

    // one tap's product, full precision.
    typedef logic signed [`FIR_DATA_WIDTH+`FIR_COEF_WIDTH-1:0] product_t;

    // adder tree sum, 4 guard bits over the product.
    typedef logic signed [`FIR_ACC_WIDTH-1:0] acc_t;

    typedef struct packed {
        logic valid;
        logic last;  // frame end.
    } fir_ctrl_t;

endpackage

`default_nettype wire

//--- include/fir_macros.svh
// FIR stage configuration.
// Widths, tap count, scaling and pipeline latencies shared by the
// filter, the scaler and the testbench.

`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

`define FIR_DATA_WIDTH      16
`define FIR_COEF_WIDTH      18  // Q2.15 signed.
`define FIR_TAP_NUM         16
`define FIR_TREE_LEVELS     4   // log2 of the tap count.
`define FIR_COEF_FRAC       15  // fraction bits dropped by the scaler.
`define FIR_ACC_WIDTH       (`FIR_DATA_WIDTH + `FIR_COEF_WIDTH + 4)

// enabled edges from sample acceptance to result.
`define FIR_FILTER_LATENCY  6
`define FIR_TOP_LATENCY     7

`endif
